//--- verilog/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	// instruction layout: op [15:12], rd [11:8], rs [7:4], rt / imm [3:0]
	// B keeps its condition in [11:9] and a signed word offset in [8:0]
	// BR jumps to the value of rs and takes no condition
	localparam int OPCODE_W = 4;
	localparam int COND_W = 3;
	localparam int ALU_OP_W = 3;
	localparam int FLAG_W = 3;
	localparam int SHAMT_W = 4; // shift amount sits in the low nibble
	localparam int MEM_OFF_W = 4; // signed LW/SW offset
	localparam int BR_OFF_W = 9; // signed, counted from pc+1
	localparam int BYTE_IMM_W = 8; // LLB/LHB immediate

	typedef logic [OPCODE_W-1:0] opcodeT;
	typedef logic [COND_W-1:0] condT;
	typedef logic [ALU_OP_W-1:0] aluOpT;
	typedef logic [FLAG_W-1:0] flagsT;

	localparam int FLAG_Z = 2; // bit positions inside flagsT
	localparam int FLAG_N = 1;
	localparam int FLAG_V = 0;

	localparam opcodeT OP_ADD = 4'd0;
	localparam opcodeT OP_SUB = 4'd1;
	localparam opcodeT OP_XOR = 4'd2;
	localparam opcodeT OP_SLL = 4'd4;
	localparam opcodeT OP_SRL = 4'd5;
	localparam opcodeT OP_LW = 4'd8;
	localparam opcodeT OP_SW = 4'd9; // rd holds the store data
	localparam opcodeT OP_LLB = 4'd10;
	localparam opcodeT OP_LHB = 4'd11;
	localparam opcodeT OP_B = 4'd12;
	localparam opcodeT OP_BR = 4'd13;
	localparam opcodeT OP_PCS = 4'd14;
	localparam opcodeT OP_HLT = 4'd15;

	localparam condT COND_NE = 3'd0;
	localparam condT COND_EQ = 3'd1;
	localparam condT COND_GT = 3'd2;
	localparam condT COND_LT = 3'd3;
	localparam condT COND_GE = 3'd4;
	localparam condT COND_LE = 3'd5;
	localparam condT COND_OV = 3'd6;
	localparam condT COND_AL = 3'd7;

	localparam aluOpT ALU_ADD = 3'd0;
	localparam aluOpT ALU_SUB = 3'd1;
	localparam aluOpT ALU_XOR = 3'd2;
	localparam aluOpT ALU_SLL = 3'd3; // also marks the high byte for LHB
	localparam aluOpT ALU_SRL = 3'd4; // also marks the low byte for LLB
	localparam aluOpT ALU_PASS = 3'd5; // pc+1 for PCS

endpackage

`default_nettype wire

//--- verilog/cpuPipePkg.sv
`default_nettype none

package cpuPipePkg;

	localparam int WORD_W = 16;
	localparam int REG_AW = 4;
	localparam int REG_COUNT = 16;
	localparam int IMEM_DEPTH = 256; // words, not bytes
	localparam int DMEM_DEPTH = 256;
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	typedef logic [WORD_W-1:0] wordT; // data and instruction word
	typedef logic [REG_AW-1:0] regAddrT;
	typedef logic [WORD_W-1:0] pcT; // word address, steps by one

endpackage

`default_nettype wire

//--- verilog/fetchStage.sv
`default_nettype none

module fetchStage
	import cpuIsaPkg::*;
	import cpuPipePkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  logic loadValid, // program load strobe
	input  pcT   loadAddr,
	input  wordT loadData,
	input  logic stall,
	input  logic redirect, // taken B or BR from decode
	input  pcT   redirectPc,
	output pcT   pc,
	output wordT dInstr,
	output pcT   dPc,
	output logic dValid
);

	wordT imem [IMEM_DEPTH];
	wordT fetched;
	logic isHlt;

	always_ff @(posedge clk) begin
		if (loadValid) begin
			imem[loadAddr[IMEM_AW-1:0]] <= loadData; // works in reset too
		end
	end

	assign fetched = imem[pc[IMEM_AW-1:0]];
	assign isHlt = fetched[WORD_W-1 -: OPCODE_W] == OP_HLT; // park on HLT

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirectPc; // redirect beats stall and HLT
		end else if (!stall && !isHlt) begin
			pc <= pc + pcT'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dValid <= 1'b0;
		end else if (redirect) begin
			dValid <= 1'b0; // wrong-path slot becomes a bubble
		end else if (!stall) begin
			dValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			dInstr <= fetched;
			dPc <= pc;
		end
	end

	// decode only redirects once its operands are ready
	aRedirectNoStall: assert property (@(posedge clk) disable iff (!rstN)
		!(redirect && stall))
		else $error("fetch: redirect while stalled");

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`default_nettype none

module decodeStage
	import cpuIsaPkg::*;
	import cpuPipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  wordT    dInstr,
	input  pcT      dPc,
	input  logic    dValid,
	input  flagsT   xFlags, // live flags from execute
	input  regAddrT wReg, // register file write port
	input  logic    wWe,
	input  wordT    wData,
	output logic    stall,
	output logic    redirect,
	output pcT      redirectPc,
	output logic    xValid,
	output aluOpT   xOp,
	output regAddrT xSrcA,
	output regAddrT xSrcB,
	output regAddrT xDst,
	output wordT    xA,
	output wordT    xB,
	output wordT    xImm,
	output logic    xWe,
	output logic    xIsLoad,
	output logic    xIsStore,
	output logic    xIsLinkOrByte,
	output logic    xHalt,
	output pcT      xPcNext
);

	wordT rf [REG_COUNT];
	opcodeT op;
	condT cond;
	regAddrT rd, rs, rt, srcA, srcB;
	regAddrT prevDst; // destination of the slot now in memory
	aluOpT aluOp;
	wordT imm, memOff, brOff, rdA, rdB;
	pcT pcNext;
	logic useA, useB, we, isLoad, isStore, isLinkOrByte, isHalt, isB, isBr;
	logic loadUse, brHazX, brHazM, prevWe, taken;

	function automatic logic condMet(condT c, flagsT f);
		logic z, n, v;
		z = f[FLAG_Z];
		n = f[FLAG_N];
		v = f[FLAG_V];
		case (c)
			COND_NE: return !z;
			COND_EQ: return z;
			COND_GT: return !z && !n;
			COND_LT: return n;
			COND_GE: return z || !n;
			COND_LE: return z || n;
			COND_OV: return v;
			COND_AL: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign op = dInstr[WORD_W-1 -: OPCODE_W];
	assign rd = dInstr[11:8];
	assign rs = dInstr[7:4];
	assign rt = dInstr[3:0];
	assign cond = dInstr[11 -: COND_W];
	assign memOff = {{(WORD_W-MEM_OFF_W){dInstr[MEM_OFF_W-1]}}, dInstr[MEM_OFF_W-1:0]};
	assign brOff = {{(WORD_W-BR_OFF_W){dInstr[BR_OFF_W-1]}}, dInstr[BR_OFF_W-1:0]};
	assign pcNext = dPc + pcT'(1);

	always_comb begin
		srcA = rs;
		srcB = rt;
		aluOp = ALU_ADD;
		imm = '0;
		{useA, useB, we, isLoad, isStore} = '0;
		{isLinkOrByte, isHalt, isB, isBr} = '0;
		case (op)
			OP_ADD, OP_SUB, OP_XOR: begin
				useA = 1'b1;
				useB = 1'b1;
				we = 1'b1;
				aluOp = (op == OP_ADD) ? ALU_ADD : (op == OP_SUB) ? ALU_SUB : ALU_XOR;
			end
			OP_SLL, OP_SRL: begin
				useA = 1'b1;
				we = 1'b1;
				aluOp = (op == OP_SLL) ? ALU_SLL : ALU_SRL;
				imm = wordT'(dInstr[SHAMT_W-1:0]);
			end
			OP_LW, OP_SW: begin
				useA = 1'b1; // base in rs
				we = (op == OP_LW);
				isLoad = (op == OP_LW);
				isStore = (op == OP_SW);
				srcB = rd; // store data that memory patches up after a load
				imm = memOff;
			end
			OP_LLB, OP_LHB: begin
				srcA = rd; // merge into the old rd
				useA = 1'b1;
				we = 1'b1;
				isLinkOrByte = 1'b1;
				aluOp = (op == OP_LHB) ? ALU_SLL : ALU_SRL;
				imm = wordT'(dInstr[BYTE_IMM_W-1:0]);
			end
			OP_PCS: begin
				we = 1'b1;
				isLinkOrByte = 1'b1;
				aluOp = ALU_PASS;
			end
			OP_B: isB = 1'b1;
			OP_BR: isBr = 1'b1;
			OP_HLT: isHalt = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wWe) begin
			rf[wReg] <= wData;
		end
	end

	assign rdA = (wWe && wReg == srcA) ? wData : rf[srcA]; // write-through
	assign rdB = (wWe && wReg == srcB) ? wData : rf[srcB];

	assign loadUse = xIsLoad && ((useA && xDst == srcA) || (useB && xDst == srcB));
	assign brHazX = isBr && xWe && xDst == rs; // rs not written yet
	assign brHazM = isBr && prevWe && prevDst == rs; // writer has to reach write-back
	assign stall = dValid && (loadUse || brHazX || brHazM);

	// copy of the execute slot as it moves on to memory
	always_ff @(posedge clk) begin
		if (!rstN) begin
			prevWe <= 1'b0;
		end else begin
			prevWe <= xWe;
		end
	end

	always_ff @(posedge clk) begin
		prevDst <= xDst;
	end

	assign taken = isBr || (isB && condMet(cond, xFlags));
	assign redirect = dValid && !stall && taken;
	assign redirectPc = isBr ? rdA : pcNext + brOff;

	always_ff @(posedge clk) begin
		if (!rstN || stall || !dValid) begin
			xValid <= 1'b0; // bubble
			xWe <= 1'b0;
			xIsLoad <= 1'b0;
			xIsStore <= 1'b0;
			xIsLinkOrByte <= 1'b0;
			xHalt <= 1'b0;
		end else begin
			xValid <= 1'b1;
			xWe <= we;
			xIsLoad <= isLoad;
			xIsStore <= isStore;
			xIsLinkOrByte <= isLinkOrByte;
			xHalt <= isHalt;
		end
	end

	always_ff @(posedge clk) begin
		xOp <= aluOp;
		xSrcA <= srcA;
		xSrcB <= srcB;
		xDst <= rd;
		xA <= rdA;
		xB <= rdB;
		xImm <= imm;
		xPcNext <= pcNext;
	end

	// a stalled instruction waits in decode for its operands
	aStallHolds: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> dValid && $stable(dInstr) && $stable(dPc))
		else $error("decode: stalled instruction was not held by fetch");

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`default_nettype none

module executeStage
	import cpuIsaPkg::*;
	import cpuPipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    xValid,
	input  aluOpT   xOp,
	input  regAddrT xSrcA,
	input  regAddrT xSrcB,
	input  regAddrT xDst,
	input  wordT    xA,
	input  wordT    xB,
	input  wordT    xImm,
	input  logic    xWe,
	input  logic    xIsLoad,
	input  logic    xIsStore,
	input  logic    xIsLinkOrByte,
	input  logic    xHalt,
	input  pcT      xPcNext,
	input  regAddrT mFwdReg,
	input  logic    mFwdWe,
	input  wordT    mFwdData,
	input  regAddrT wReg,
	input  logic    wWe,
	input  wordT    wData,
	output flagsT   xFlags,
	output logic    mValid,
	output wordT    mResult,
	output wordT    mStoreData,
	output regAddrT mDst,
	output logic    mWe,
	output logic    mIsLoad,
	output logic    mIsStore,
	output logic    mHalt
);

	wordT opA, opB, aluB, sum, diff, aluOut, byteOut, result;
	flagsT flags, newFlags;
	logic vf, isShift, updFlags;

	// newest producer wins, memory before write-back
	function automatic wordT fwdSel(regAddrT src, wordT regVal, regAddrT mReg, logic mWeIn,
			wordT mData, regAddrT wRegIn, logic wWeIn, wordT wDataIn);
		if (mWeIn && mReg == src) return mData;
		if (wWeIn && wRegIn == src) return wDataIn;
		return regVal;
	endfunction

	always_comb begin
		opA = fwdSel(xSrcA, xA, mFwdReg, mFwdWe, mFwdData, wReg, wWe, wData);
		opB = fwdSel(xSrcB, xB, mFwdReg, mFwdWe, mFwdData, wReg, wWe, wData);
	end

	assign aluB = (xIsLoad || xIsStore) ? xImm : opB; // address = rs + offset
	assign sum = opA + aluB;
	assign diff = opA - opB;

	always_comb begin
		vf = 1'b0;
		case (xOp)
			ALU_ADD: begin
				aluOut = sum;
				vf = (opA[WORD_W-1] == aluB[WORD_W-1]) && (sum[WORD_W-1] != opA[WORD_W-1]);
			end
			ALU_SUB: begin
				aluOut = diff;
				vf = (opA[WORD_W-1] != opB[WORD_W-1]) && (diff[WORD_W-1] != opA[WORD_W-1]);
			end
			ALU_XOR: aluOut = opA ^ opB;
			ALU_SLL: aluOut = opA << xImm[SHAMT_W-1:0];
			ALU_SRL: aluOut = opA >> xImm[SHAMT_W-1:0]; // logical
			ALU_PASS: aluOut = xPcNext;
			default: aluOut = opA;
		endcase
	end

	// LHB rides on the SLL select, LLB on SRL
	assign byteOut = (xOp == ALU_SLL) ? {xImm[BYTE_IMM_W-1:0], opA[7:0]}
		: {opA[WORD_W-1:8], xImm[BYTE_IMM_W-1:0]};
	assign result = (xIsLinkOrByte && xOp != ALU_PASS) ? byteOut : aluOut;

	assign isShift = (xOp == ALU_SLL) || (xOp == ALU_SRL);
	assign updFlags = xValid && xWe && !xIsLoad && !xIsLinkOrByte; // arith and shifts only

	always_comb begin
		newFlags[FLAG_Z] = (aluOut == '0);
		newFlags[FLAG_N] = aluOut[WORD_W-1];
		newFlags[FLAG_V] = isShift ? flags[FLAG_V] : vf; // shifts leave V alone
	end

	assign xFlags = updFlags ? newFlags : flags; // decode sees this cycle's flags

	always_ff @(posedge clk) begin
		if (!rstN) begin
			flags <= '0;
		end else if (updFlags) begin
			flags <= newFlags;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			mValid <= 1'b0;
			mWe <= 1'b0;
			mIsLoad <= 1'b0;
			mIsStore <= 1'b0;
			mHalt <= 1'b0;
		end else begin
			mValid <= xValid;
			mWe <= xWe;
			mIsLoad <= xIsLoad;
			mIsStore <= xIsStore;
			mHalt <= xHalt;
		end
	end

	always_ff @(posedge clk) begin
		mResult <= result;
		mStoreData <= opB;
		mDst <= xDst;
	end

endmodule

`default_nettype wire

//--- verilog/memoryStage.sv
`default_nettype none

module memoryStage
	import cpuPipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    mValid,
	input  wordT    mResult, // ALU result or data address
	input  wordT    mStoreData,
	input  regAddrT mDst, // for SW this names the data register
	input  logic    mWe,
	input  logic    mIsLoad,
	input  logic    mIsStore,
	input  logic    mHalt,
	output regAddrT mFwdReg,
	output logic    mFwdWe,
	output wordT    mFwdData,
	output regAddrT wReg,
	output logic    wWe,
	output wordT    wData,
	output logic    wValid,
	output logic    wHalt
);

	wordT dmem [DMEM_DEPTH];
	wordT storeData;
	logic [DMEM_AW-1:0] addr;

	assign addr = mResult[DMEM_AW-1:0];

	// LW right before SW reaches here only now
	assign storeData = (wWe && wReg == mDst) ? wData : mStoreData;

	always_ff @(posedge clk) begin
		if (mValid && mIsStore) begin
			dmem[addr] <= storeData;
		end
	end

	assign mFwdReg = mDst;
	assign mFwdWe = mWe && !mIsLoad; // load data not ready until write-back
	assign mFwdData = mResult;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wValid <= 1'b0;
			wWe <= 1'b0;
			wHalt <= 1'b0;
		end else begin
			wValid <= mValid;
			wWe <= mWe;
			wHalt <= mHalt;
		end
	end

	always_ff @(posedge clk) begin
		wReg <= mDst;
		wData <= mIsLoad ? dmem[addr] : mResult; // registered read
	end

	aLoadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(mIsLoad && mIsStore))
		else $error("memory: load and store in the same slot");

endmodule

`default_nettype wire

//--- verilog/cpuTop.sv
`default_nettype none

module cpuTop
	import cpuIsaPkg::*;
	import cpuPipePkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    loadValid,
	input  pcT      loadAddr,
	input  wordT    loadData,
	output logic    wbValid, // one strobe per retired register write
	output regAddrT wbReg,
	output wordT    wbData,
	output logic    hlt,
	output pcT      pc
);

	wordT dInstr, xA, xB, xImm, mResult, mStoreData, mFwdData, wData;
	pcT dPc, redirectPc, xPcNext;
	logic dValid, stall, redirect;
	logic xValid, xWe, xIsLoad, xIsStore, xIsLinkOrByte, xHalt;
	aluOpT xOp;
	regAddrT xSrcA, xSrcB, xDst, mDst, mFwdReg, wReg;
	flagsT xFlags;
	logic mValid, mWe, mIsLoad, mIsStore, mHalt, mFwdWe;
	logic wWe, wValid, wHalt, hltSeen;

	fetchStage uFetch (
		.clk, .rstN, .loadValid, .loadAddr, .loadData,
		.stall, .redirect, .redirectPc,
		.pc, .dInstr, .dPc, .dValid
	);

	decodeStage uDecode (
		.clk, .rstN, .dInstr, .dPc, .dValid, .xFlags,
		.wReg, .wWe, .wData,
		.stall, .redirect, .redirectPc,
		.xValid, .xOp, .xSrcA, .xSrcB, .xDst, .xA, .xB, .xImm,
		.xWe, .xIsLoad, .xIsStore, .xIsLinkOrByte, .xHalt, .xPcNext
	);

	executeStage uExecute (
		.clk, .rstN,
		.xValid, .xOp, .xSrcA, .xSrcB, .xDst, .xA, .xB, .xImm,
		.xWe, .xIsLoad, .xIsStore, .xIsLinkOrByte, .xHalt, .xPcNext,
		.mFwdReg, .mFwdWe, .mFwdData, .wReg, .wWe, .wData,
		.xFlags, .mValid, .mResult, .mStoreData, .mDst,
		.mWe, .mIsLoad, .mIsStore, .mHalt
	);

	memoryStage uMemory (
		.clk, .rstN,
		.mValid, .mResult, .mStoreData, .mDst, .mWe, .mIsLoad, .mIsStore, .mHalt,
		.mFwdReg, .mFwdWe, .mFwdData, .wReg, .wWe, .wData, .wValid, .wHalt
	);

	assign wbValid = wValid && wWe;
	assign wbReg = wReg;
	assign wbData = wData;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			hltSeen <= 1'b0;
		end else if (wHalt) begin
			hltSeen <= 1'b1; // sticky until the next reset
		end
	end

	assign hlt = hltSeen || wHalt; // high in the cycle HLT reaches write-back

endmodule

`default_nettype wire

//--- verification/cpuTb.sv
`default_nettype none

module cpuTb
	import cpuPipePkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam string STIM_FILE = "verification/cpuStimulus.txt";
	localparam int TAIL_CYCLES = 10; // quiet cycles watched after hlt

	logic clk;
	logic rstN;
	logic loadValid;
	pcT loadAddr;
	wordT loadData;
	logic wbValid;
	logic [3:0] wbReg;
	wordT wbData;
	logic hlt;
	pcT pc;

	wordT progMem[$]; // program words in address order
	logic [3:0] expReg[$]; // expected write-back trace
	wordT expData[$];
	pcT finalPc;
	int errors = 0;
	int checks = 0;
	int strobes = 0; // write strobes seen so far
	bit loaded = 0; // arms the watchdog
	bit stimOk;

	cpuTop dut (
		.clk, .rstN, .loadValid, .loadAddr, .loadData,
		.wbValid, .wbReg, .wbData, .hlt, .pc
	);

	always #5 clk = ~clk;

	// next line that holds data, comment and blank lines skipped
	task automatic nextLine(input int fd, output string line);
		line = "";
		while (!$feof(fd)) begin
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin
				return;
			end
		end
		line = "";
	endtask

	task automatic loadStimulus(output bit ok);
		int fd, count, got, nTrace;
		string line;
		logic [15:0] w[8];
		logic [15:0] r, v;
		ok = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			errors++;
			return;
		end
		nextLine(fd, line);
		count = 0;
		void'($sscanf(line, "%d", count));
		while (progMem.size() < count) begin
			nextLine(fd, line);
			got = $sscanf(line, "%h %h %h %h %h %h %h %h",
				w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
			if (got <= 0) begin
				$display("stimulus file ends inside the program words");
				errors++;
				$fclose(fd);
				return;
			end
			for (int i = 0; i < got; i++) begin
				progMem.push_back(w[i]);
			end
		end
		nextLine(fd, line);
		nTrace = 0;
		void'($sscanf(line, "%d", nTrace));
		for (int i = 0; i < nTrace; i++) begin
			nextLine(fd, line);
			void'($sscanf(line, "%h %h", r, v));
			expReg.push_back(r[3:0]);
			expData.push_back(v);
		end
		nextLine(fd, line);
		void'($sscanf(line, "%h", finalPc));
		$fclose(fd);
		ok = 1'b1;
	endtask

	task automatic checkValue(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic checkQuietOutputs(input string phase);
		checkValue({phase, " wbValid"}, 16'd0, {15'd0, wbValid});
		checkValue({phase, " hlt"}, 16'd0, {15'd0, hlt});
		checkValue({phase, " pc"}, 16'd0, pc);
	endtask

	// one retired register write against the next trace entry
	task automatic checkStrobe();
		checks++;
		assert (strobes < expReg.size()) else begin
			errors++;
			$display("write to r%0d with data %h came after the expected trace was used up",
				wbReg, wbData);
		end
		if (strobes < expReg.size()) begin
			checkValue($sformatf("trace %0d reg", strobes), {12'd0, expReg[strobes]},
				{12'd0, wbReg});
			checkValue($sformatf("trace %0d data", strobes), expData[strobes], wbData);
		end
		strobes++;
	endtask

	task automatic runProgram();
		@(posedge clk);
		foreach (progMem[i]) begin
			#1;
			loadValid = 1'b1;
			loadAddr = pcT'(i);
			loadData = progMem[i];
			@(posedge clk);
		end
		#1 loadValid = 1'b0;
		loaded = 1'b1;
		repeat (3) begin // reset cycles after the load
			@(negedge clk);
			checkQuietOutputs("reset");
		end
		@(posedge clk);
		#1 rstN = 1'b1;
		@(negedge clk);
		checkQuietOutputs("first cycle");
		while (!hlt) begin
			if (wbValid) begin
				checkStrobe();
			end
			@(negedge clk);
		end
		repeat (TAIL_CYCLES) begin
			checks++;
			assert (!wbValid) else begin
				errors++;
				$display("write to r%0d seen after hlt went high", wbReg);
			end
			@(negedge clk);
		end
		checkValue("strobe count", 16'(expReg.size()), 16'(strobes));
		checkValue("final pc", finalPc, pc);
		checkValue("hlt sticky", 16'd1, {15'd0, hlt});
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0; // core stays in reset through the program load
		loadValid = 1'b0;
		loadAddr = '0;
		loadData = '0;
		loadStimulus(stimOk);
		if (stimOk) begin
			runProgram();
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// budget grows with program length
	initial begin
		wait (loaded);
		repeat (20 * progMem.size() + 100) @(posedge clk);
		$display("timeout: hlt never rose, %0d writes seen", strobes);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/cpuStimulus.txt
# word count, then program words eight per line (hex, address order)
# then trace count, one "reg data" pair per line, then the final pc
48
E100 A134 B112 E200 0312 1431 2543 4654
5763 4875 982F 892F 0A91 C001 EF00 C201
EB00 C601 EF00 C401 1C11 CA01 EF00 C801
EF00 BC70 0DCC CC01 EF00 1EDD CC01 C001
E300 CE02 EF00 EF00 0432 0442 D040 EF00
EF00 E500 571C 566C 1667 C1FE E800 F000
# expected write-back trace: reg data
26
1 0001
1 0034
1 1234
2 0004
3 1238
4 0004
5 123C
6 23C0
7 0478
8 8F00
9 8F00
A A134
B 0011
C 0000
C 7000
D E000
E 0000
3 0021
4 0025
4 0029
5 002A
7 0001
6 0002
6 0001
6 0000
8 002F
# final pc, parked on HLT
002F

//--- tb.f
verilog/cpuIsaPkg.sv
verilog/cpuPipePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuTop.sv
verification/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
